// File: Bender.yml
package:
  name: gba_io

sources:
  # Package first, then the blocks and the top level
  - files:
      - rtl/gba_io_pkg.sv
      - rtl/snes_controller.sv
      - rtl/io_reg_file.sv
      - rtl/led_controller.sv
      - rtl/gba_io_top.sv

  # Pad model and testbench
  - target: simulation
    files:
      - sim/snes_pad_model.sv
      - sim/tb_gba_io_top.sv

// File: flist.f
rtl/gba_io_pkg.sv
rtl/snes_controller.sv
rtl/io_reg_file.sv
rtl/led_controller.sv
rtl/gba_io_top.sv
sim/snes_pad_model.sv
sim/tb_gba_io_top.sv

// File: rtl/gba_io_pkg.sv
// ##########################################################################
// Debug I/O package: register map, bus access sizes and game-pad
// reader timing shared by the debug I/O blocks
// ##########################################################################

package gba_io_pkg;

    // Register bus byte address, 8 words
    localparam int unsigned BUS_ADDR_W = 5;

    // Debug register map (word indices)
    localparam int unsigned NUM_LED_REGS = 4;
    localparam int unsigned LED_REG0_IDX = 0;
    localparam int unsigned LED_REG1_IDX = 1;
    localparam int unsigned LED_REG2_IDX = 2;
    localparam int unsigned LED_REG3_IDX = 3;
    // Read-only button word, upper half reads zero
    localparam int unsigned KEYINPUT_IDX = 4;

    // Access size, same encoding as the CPU bus
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } bus_size_e;

    // Game-pad reader phases
    typedef enum logic [1:0] {
        GAP,
        LATCH,
        CLK_LOW,
        CLK_HIGH
    } snes_state_e;

    // Reader timing in system clock cycles
    localparam int unsigned SNES_HALF_PERIOD = 8;
    localparam int unsigned SNES_BITS        = 16;
    localparam int unsigned SNES_GAP_CYCLES  = 16;

endpackage : gba_io_pkg

// File: rtl/gba_io_top.sv
// ##########################################################################
// Debug I/O top: game-pad reader, debug registers and LED selector
// ##########################################################################

`timescale 1ns/1ps

module gba_io_top (
    input  logic                              clock,
    input  logic                              rst,
    input  logic [7:0]                        sw,
    input  logic                              serial_data,
    input  logic [gba_io_pkg::BUS_ADDR_W-1:0] bus_addr,
    input  logic [31:0]                       bus_wdata,
    input  logic [1:0]                        bus_size,
    input  logic                              bus_write,
    output logic                              data_latch,
    output logic                              data_clock,
    output logic [31:0]                       bus_rdata,
    output logic [7:0]                        ld
);

    // Pressed-buttons word, active high
    logic [15:0] buttons;

    logic [31:0] led_reg0;
    logic [31:0] led_reg1;
    logic [31:0] led_reg2;
    logic [31:0] led_reg3;

    snes_controller cont (
        .clock, .rst, .serial_data, .data_latch, .data_clock, .buttons
    );

    io_reg_file regs (
        .clock, .rst, .bus_addr, .bus_wdata, .bus_size, .bus_write,
        .buttons, .bus_rdata,
        .led_reg0, .led_reg1, .led_reg2, .led_reg3
    );

    led_controller led (
        .sw, .led_reg0, .led_reg1, .led_reg2, .led_reg3, .buttons, .ld
    );

endmodule : gba_io_top

// File: rtl/io_reg_file.sv
// ##########################################################################
// Debug register file: four 32-bit registers with byte-lane writes,
// read-back of the registers and the button word
// ##########################################################################

`timescale 1ns/1ps

module io_reg_file (
    input  logic                              clock,
    input  logic                              rst,
    input  logic [gba_io_pkg::BUS_ADDR_W-1:0] bus_addr,
    input  logic [31:0]                       bus_wdata,
    input  logic [1:0]                        bus_size,
    input  logic                              bus_write,
    input  logic [15:0]                       buttons,
    output logic [31:0]                       bus_rdata,
    output logic [31:0]                       led_reg0,
    output logic [31:0]                       led_reg1,
    output logic [31:0]                       led_reg2,
    output logic [31:0]                       led_reg3
);

    logic [31:0] regs [gba_io_pkg::NUM_LED_REGS];

    logic [2:0]  word_idx;
    logic [3:0]  byte_en;
    logic [31:0] wdata_rep;

    assign word_idx = bus_addr[4:2];

    // Lane enables and data replicated across the word
    always_comb begin
        byte_en   = 4'b0000;
        wdata_rep = bus_wdata;
        case (gba_io_pkg::bus_size_e'(bus_size))
            gba_io_pkg::SIZE_BYTE: begin
                byte_en[bus_addr[1:0]] = 1'b1;
                wdata_rep = {4{bus_wdata[7:0]}};
            end
            gba_io_pkg::SIZE_HALF: begin
                byte_en   = bus_addr[1] ? 4'b1100 : 4'b0011;
                wdata_rep = {2{bus_wdata[15:0]}};
            end
            gba_io_pkg::SIZE_WORD: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < gba_io_pkg::NUM_LED_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (bus_write) begin
            for (int i = 0; i < gba_io_pkg::NUM_LED_REGS; i++) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (word_idx == 3'(i) && byte_en[lane]) begin
                        regs[i][lane*8 +: 8] <= wdata_rep[lane*8 +: 8];
                    end
                end
            end
        end
    end

    // Unmapped words read as zero
    always_comb begin
        case (word_idx)
            3'(gba_io_pkg::LED_REG0_IDX): bus_rdata = regs[gba_io_pkg::LED_REG0_IDX];
            3'(gba_io_pkg::LED_REG1_IDX): bus_rdata = regs[gba_io_pkg::LED_REG1_IDX];
            3'(gba_io_pkg::LED_REG2_IDX): bus_rdata = regs[gba_io_pkg::LED_REG2_IDX];
            3'(gba_io_pkg::LED_REG3_IDX): bus_rdata = regs[gba_io_pkg::LED_REG3_IDX];
            3'(gba_io_pkg::KEYINPUT_IDX): bus_rdata = {16'h0000, buttons};
            default:                      bus_rdata = 32'h0000_0000;
        endcase
    end

    assign led_reg0 = regs[gba_io_pkg::LED_REG0_IDX];
    assign led_reg1 = regs[gba_io_pkg::LED_REG1_IDX];
    assign led_reg2 = regs[gba_io_pkg::LED_REG2_IDX];
    assign led_reg3 = regs[gba_io_pkg::LED_REG3_IDX];

endmodule : io_reg_file

// File: rtl/led_controller.sv
// ##########################################################################
// LED selector: switches pick one byte of the debug registers or buttons
// ##########################################################################

`timescale 1ns/1ps

module led_controller (
    input  logic [7:0]  sw,
    input  logic [31:0] led_reg0,
    input  logic [31:0] led_reg1,
    input  logic [31:0] led_reg2,
    input  logic [31:0] led_reg3,
    input  logic [15:0] buttons,
    output logic [7:0]  ld
);

    logic [31:0] sel_reg;

    // Register chosen by sw[3:2]
    always_comb begin
        case (sw[3:2])
            2'd0:    sel_reg = led_reg0;
            2'd1:    sel_reg = led_reg1;
            2'd2:    sel_reg = led_reg2;
            default: sel_reg = led_reg3;
        endcase
    end

    always_comb begin
        if (sw[7:4] == 4'h0) begin
            // Byte sw[1:0] of the selected register
            ld = sel_reg[sw[1:0]*8 +: 8];
        end else if (sw[7]) begin
            ld = buttons[15:8];
        end else begin
            ld = buttons[7:0];
        end
    end

endmodule : led_controller

// File: rtl/snes_controller.sv
// ##########################################################################
// SNES game-pad poller: drives latch and clock, collects the serial
// button bits and publishes a 16-bit active-high pressed-buttons word
// ##########################################################################

`timescale 1ns/1ps

module snes_controller (
    input  logic        clock,
    input  logic        rst,
    input  logic        serial_data,
    output logic        data_latch,
    output logic        data_clock,
    output logic [15:0] buttons
);

    gba_io_pkg::snes_state_e state;

    // Counts cycles within a phase, sized for the longer gap phase
    logic [4:0] phase_cnt;
    logic [3:0] bit_cnt;

    logic [gba_io_pkg::SNES_BITS-1:0] shift_reg;
    logic [gba_io_pkg::SNES_BITS-1:0] shift_next;

    logic half_done;
    logic gap_done;
    logic last_bit;
    logic sample;

    assign half_done = (phase_cnt == 5'(gba_io_pkg::SNES_HALF_PERIOD - 1));
    assign gap_done  = (phase_cnt == 5'(gba_io_pkg::SNES_GAP_CYCLES - 1));
    assign last_bit  = (bit_cnt == 4'(gba_io_pkg::SNES_BITS - 1));

    // Sample on the last cycle of each low phase
    assign sample = (state == gba_io_pkg::CLK_LOW) && half_done;

    // Pad sends bit 0 first, pressed is low
    assign shift_next = {~serial_data, shift_reg[gba_io_pkg::SNES_BITS-1:1]};

    // Pad lines decoded from the phase
    assign data_latch = (state == gba_io_pkg::LATCH);
    assign data_clock = (state != gba_io_pkg::CLK_LOW);

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= gba_io_pkg::GAP;
            phase_cnt <= '0;
            bit_cnt   <= '0;
        end else begin
            case (state)
                gba_io_pkg::GAP: begin
                    if (gap_done) begin
                        state     <= gba_io_pkg::LATCH;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 5'd1;
                    end
                end
                gba_io_pkg::LATCH: begin
                    if (half_done) begin
                        state     <= gba_io_pkg::CLK_LOW;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 5'd1;
                    end
                end
                gba_io_pkg::CLK_LOW: begin
                    if (half_done) begin
                        state     <= gba_io_pkg::CLK_HIGH;
                        phase_cnt <= '0;
                    end else begin
                        phase_cnt <= phase_cnt + 5'd1;
                    end
                end
                gba_io_pkg::CLK_HIGH: begin
                    if (half_done) begin
                        phase_cnt <= '0;
                        if (last_bit) begin
                            state   <= gba_io_pkg::GAP;
                            bit_cnt <= '0;
                        end else begin
                            state   <= gba_io_pkg::CLK_LOW;
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end else begin
                        phase_cnt <= phase_cnt + 5'd1;
                    end
                end
                default: begin
                    state     <= gba_io_pkg::GAP;
                    phase_cnt <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (sample) begin
            shift_reg <= shift_next;
        end
    end

    // Whole word copied once the 16th bit is in
    always_ff @(posedge clock) begin
        if (rst) begin
            buttons <= '0;
        end else if (sample && last_bit) begin
            buttons <= shift_next;
        end
    end

endmodule : snes_controller

// File: sim/snes_pad_model.sv
// ##########################################################################
// Behavioral SNES game pad: shifts out an active-low button word,
// reloaded on latch and advanced on each rising pad clock
// ##########################################################################

`timescale 1ns/1ps

module snes_pad_model (
    input  logic        data_latch,
    input  logic        data_clock,
    input  logic [15:0] pressed,
    output logic        serial_data
);

    logic [15:0] shift_reg;

    initial begin
        shift_reg = '0;
    end

    // Reload on latch, next bit on each rising pad clock
    always @(posedge data_latch or posedge data_clock) begin
        if (data_latch) begin
            shift_reg <= pressed;
        end else begin
            shift_reg <= {1'b0, shift_reg[15:1]};
        end
    end

    // Pressed button pulls the line low
    assign serial_data = ~shift_reg[0];

endmodule : snes_pad_model

// File: sim/tb_gba_io_top.sv
// ##########################################################################
// Debug I/O testbench: register bus, LED selector and game-pad reader
// ##########################################################################

`timescale 1ns/1ps

module tb_gba_io_top;

    localparam int CLK_PERIOD      = 40;
    localparam int FRAME_CYCLES    = gba_io_pkg::SNES_GAP_CYCLES
        + gba_io_pkg::SNES_HALF_PERIOD * (1 + 2 * gba_io_pkg::SNES_BITS);
    localparam int WATCHDOG_CYCLES = 5 * FRAME_CYCLES + 200;

    logic                              clock;
    logic                              rst;
    logic [7:0]                        sw;
    logic [gba_io_pkg::BUS_ADDR_W-1:0] bus_addr;
    logic [31:0]                       bus_wdata;
    logic [1:0]                        bus_size;
    logic                              bus_write;
    logic [15:0]                       pressed;
    logic                              serial_data;
    logic                              data_latch;
    logic                              data_clock;
    logic [31:0]                       bus_rdata;
    logic [7:0]                        ld;

    // Expected debug registers and button word
    logic [31:0] model [gba_io_pkg::NUM_LED_REGS];
    logic [15:0] exp_buttons;
    int          seed = 7;

    gba_io_top UUT (
        .clock, .rst, .sw, .serial_data, .bus_addr, .bus_wdata, .bus_size,
        .bus_write, .data_latch, .data_clock, .bus_rdata, .ld
    );

    snes_pad_model pad (
        .data_latch, .data_clock, .pressed, .serial_data
    );

    initial begin
        clock = 1'b0;
    end

    always #(CLK_PERIOD / 2) clock = ~clock;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Value mismatch");
        end
    endtask

    function automatic logic [31:0] expected_word(input int idx);
        if (idx < gba_io_pkg::NUM_LED_REGS) begin
            return model[idx];
        end else if (idx == gba_io_pkg::KEYINPUT_IDX) begin
            return {16'h0000, exp_buttons};
        end
        return 32'h0000_0000;
    endfunction

    // Low 16 switch values pick a register byte, others the buttons
    function automatic logic [7:0] expected_led(input logic [7:0] sw_val);
        logic [31:0] word;
        if (sw_val < 8'h10) begin
            word = model[sw_val / 4];
            return word[(sw_val % 4) * 8 +: 8];
        end
        return sw_val[7] ? exp_buttons[15:8] : exp_buttons[7:0];
    endfunction

    task automatic bus_store(input logic [gba_io_pkg::BUS_ADDR_W-1:0] addr,
                             input logic [1:0] size, input logic [31:0] data);
        int idx;
        @(negedge clock);
        bus_addr  = addr;
        bus_size  = size;
        bus_wdata = data;
        bus_write = 1'b1;
        @(negedge clock);
        bus_write = 1'b0;
        idx = addr[4:2];
        if (idx < gba_io_pkg::NUM_LED_REGS) begin
            case (size)
                gba_io_pkg::SIZE_BYTE: model[idx][addr[1:0] * 8 +: 8] = data[7:0];
                gba_io_pkg::SIZE_HALF: model[idx][addr[1] * 16 +: 16] = data[15:0];
                gba_io_pkg::SIZE_WORD: model[idx] = data;
                default: begin
                end
            endcase
        end
        // Read-back in the cycle right after the strobe
        #(CLK_PERIOD / 4);
        compare_value($sformatf("bus_rdata[store 0x%02h]", addr), bus_rdata,
                      expected_word(idx));
    endtask

    task automatic read_word(input int idx);
        @(negedge clock);
        bus_addr = 5'(idx * 4);
        #(CLK_PERIOD / 4);
        compare_value($sformatf("bus_rdata[word %0d]", idx), bus_rdata, expected_word(idx));
    endtask

    task automatic led_check(input logic [7:0] sw_val);
        @(negedge clock);
        sw = sw_val;
        #(CLK_PERIOD / 4);
        compare_value($sformatf("ld[sw=0x%02h]", sw_val), {24'h0, ld},
                      {24'h0, expected_led(sw_val)});
    endtask

    task automatic test_reset_state();
        int i;
        for (i = 0; i < gba_io_pkg::NUM_LED_REGS; i++) begin
            model[i] = '0;
        end
        rst = 1'b1;
        repeat (2) begin
            @(negedge clock);
            compare_value("data_latch", {31'h0, data_latch}, 32'h0);
            compare_value("data_clock", {31'h0, data_clock}, 32'h1);
        end
        rst = 1'b0;
        // Reader idles in its gap after reset
        repeat (8) begin
            @(negedge clock);
            compare_value("data_latch", {31'h0, data_latch}, 32'h0);
            compare_value("data_clock", {31'h0, data_clock}, 32'h1);
        end
        for (i = 0; i < 8; i++) begin
            read_word(i);
        end
        for (i = 0; i < 16; i++) begin
            led_check(8'(i));
        end
    endtask

    task automatic test_word_writes();
        int i;
        for (i = 0; i < gba_io_pkg::NUM_LED_REGS; i++) begin
            bus_store(5'(i * 4), gba_io_pkg::SIZE_WORD, $random(seed));
            read_word(i);
        end
        for (i = 0; i < 16; i++) begin
            led_check(8'(i));
        end
    endtask

    task automatic test_partial_writes();
        int i;
        int lane;
        for (i = 0; i < gba_io_pkg::NUM_LED_REGS; i++) begin
            for (lane = 0; lane < 4; lane++) begin
                bus_store(5'(i * 4 + lane), gba_io_pkg::SIZE_BYTE, $random(seed));
                read_word(i);
            end
            for (lane = 0; lane < 2; lane++) begin
                bus_store(5'(i * 4 + lane * 2), gba_io_pkg::SIZE_HALF, $random(seed));
                read_word(i);
            end
        end
        for (i = 0; i < gba_io_pkg::NUM_LED_REGS; i++) begin
            read_word(i);
        end
    endtask

    task automatic test_ignored_writes();
        int i;
        bus_store(5'(gba_io_pkg::KEYINPUT_IDX * 4), gba_io_pkg::SIZE_WORD, 32'hFFFF_FFFF);
        for (i = 5; i < 8; i++) begin
            bus_store(5'(i * 4), gba_io_pkg::SIZE_WORD, $random(seed));
        end
        for (i = 0; i < 8; i++) begin
            read_word(i);
        end
    endtask

    task automatic test_pad_buttons(input logic [15:0] pattern);
        @(negedge clock);
        pressed = pattern;
        // A pad change shows up within two poll frames
        repeat (2 * FRAME_CYCLES) @(negedge clock);
        exp_buttons = pattern;
        read_word(gba_io_pkg::KEYINPUT_IDX);
        led_check(8'h10);
        led_check(8'h80);
    endtask

    task automatic test_random_writes();
        int n;
        int unsigned size_sel;
        logic [gba_io_pkg::BUS_ADDR_W-1:0] addr;
        for (n = 0; n < 30; n++) begin
            size_sel = $unsigned($random(seed)) % 3;
            addr     = 5'($random(seed));
            bus_store(addr, 2'(size_sel), $random(seed));
            read_word(addr[4:2]);
        end
    endtask

    initial begin
        rst         = 1'b1;
        sw          = '0;
        bus_addr    = '0;
        bus_wdata   = '0;
        bus_size    = gba_io_pkg::SIZE_WORD;
        bus_write   = 1'b0;
        pressed     = '0;
        exp_buttons = '0;
        test_reset_state();
        test_word_writes();
        test_partial_writes();
        test_ignored_writes();
        test_pad_buttons(16'hA5C3);
        test_pad_buttons(16'h0F81);
        test_random_writes();
        $display("NO ERRORS");
        $finish;
    end

endmodule : tb_gba_io_top
